//--- rtl/lane_seq_pkg.sv
// Lane sequencer definitions
`default_nettype none

package lane_seq_pkg;

  //////////////////////////////
  // Lane geometry
  //////////////////////////////

  // Lanes in the vector unit and the width of a lane index
  localparam int unsigned nr_lanes  = 4;
  localparam int unsigned lane_id_w = 2;

  // Instruction IDs that may be in flight at once
  localparam int unsigned nr_vinsn = 8;
  localparam int unsigned vid_w    = 3;

  // Vector length and start element width
  localparam int unsigned vl_w = 16;

  // Operand queues served by this sequencer
  localparam int unsigned nr_opq = 6;

  // Mask bits packed into one byte of the mask register
  localparam int unsigned mask_bits_per_byte = 8;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  typedef logic [vid_w-1:0]    vid_t;
  typedef logic [vl_w-1:0]     vlen_t;
  typedef logic [nr_vinsn-1:0] vinsn_mask_t;

  // Target functional unit of an instruction
  typedef enum logic [1:0] {
    vfu_none = 2'd0,
    vfu_alu  = 2'd1,
    vfu_mfpu = 2'd2
  } vfu_e;

  // Selected element width
  typedef enum logic [1:0] {
    ew8  = 2'd0,
    ew16 = 2'd1,
    ew32 = 2'd2,
    ew64 = 2'd3
  } vsew_e;

  // Index of each operand queue slot
  typedef enum logic [2:0] {
    opq_alu_a  = 3'd0,
    opq_alu_b  = 3'd1,
    opq_mfpu_a = 3'd2,
    opq_mfpu_b = 3'd3,
    opq_mfpu_c = 3'd4,
    opq_mask_m = 3'd5
  } opq_e;

  //////////////////////////////
  // Request and command words
  //////////////////////////////

  // Instruction as broadcast by the main sequencer to every lane
  typedef struct packed {
    vid_t        id;
    vfu_e        vfu;
    logic [5:0]  op;
    logic        vm;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    logic [4:0]  vd;
    logic        use_vs1;
    logic        use_vs2;
    logic        use_vd_op;
    vlen_t       vl;
    vlen_t       vstart;
    vsew_e       vsew;
    vinsn_mask_t hazard_vs1;
    vinsn_mask_t hazard_vs2;
    vinsn_mask_t hazard_vd;
    vinsn_mask_t hazard_vm;
  } pe_req_t;

  // Operation handed to the lane's functional units, with lane-local length
  typedef struct packed {
    vid_t       id;
    vfu_e       vfu;
    logic [5:0] op;
    logic       vm;
    logic [4:0] vd;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd_op;
    vsew_e      vsew;
    vlen_t      vl;
    vlen_t      vstart;
  } vfu_op_t;

  // Command for one operand requester
  typedef struct packed {
    vid_t        id;
    logic [4:0]  vs;
    vsew_e       eew;
    vlen_t       vl;
    vlen_t       vstart;
    vinsn_mask_t hazard;
  } opq_cmd_t;

endpackage

`default_nettype wire

//--- rtl/lane_issue_if.sv
// Dispatch to issue link
`default_nettype none

interface lane_issue_if import lane_seq_pkg::*; ();

  // Commands and push strobes, one per operand queue
  opq_cmd_t [nr_opq-1:0] opq_cmd;
  logic     [nr_opq-1:0] opq_push;

  // Operation for the functional units
  vfu_op_t vfu_op;
  logic    vfu_op_push;

  // Instructions finished on the spot because this lane has no elements
  vinsn_mask_t muted_done;

  // Current occupancy of each operand queue slot
  logic [nr_opq-1:0] opq_busy;

  modport dispatch (
    output opq_cmd,
    output opq_push,
    output vfu_op,
    output vfu_op_push,
    output muted_done,
    input  opq_busy
  );

  modport issue (
    input  opq_cmd,
    input  opq_push,
    input  vfu_op,
    input  vfu_op_push,
    input  muted_done,
    output opq_busy
  );

endinterface

`default_nettype wire

//--- rtl/lane_req_capture.sv
// Request capture stage
`default_nettype none

module lane_req_capture import lane_seq_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Broadcast from the main sequencer
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output logic    pe_req_ready_o,
  // Towards dispatch
  output pe_req_t req_o,
  output logic    req_valid_o,
  input  logic    req_ready_i
);

  //////////////////////////////
  // Duplicate filter
  //////////////////////////////

  // The main sequencer keeps broadcasting an instruction until all lanes took it
  vid_t last_id_q;
  logic sync_q;
  logic valid_msk;
  logic push;

  // Register contents of the one-entry buffer
  pe_req_t data_q;
  logic    full_q;

  always_comb begin
    // A broadcast carrying the ID we already took is invisible while synced
    valid_msk = pe_req_valid_i && !(sync_q && (pe_req_i.id == last_id_q));

    // Only an empty buffer accepts a new request
    pe_req_ready_o = !full_q;
    push           = valid_msk && pe_req_ready_o;

    // Fall through when empty, so dispatch sees the request at once
    req_valid_o = full_q || valid_msk;
    req_o       = full_q ? data_q : pe_req_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_id_q <= '0;
      sync_q    <= 1'b0;
      full_q    <= 1'b0;
    end else begin
      // Remember what was taken, forget it once the broadcast ends
      if (push) begin
        last_id_q <= pe_req_i.id;
        sync_q    <= 1'b1;
      end else if (!pe_req_valid_i) begin
        sync_q <= 1'b0;
      end
      // Buffer fills only when dispatch did not take the request directly
      if (full_q && req_ready_i) begin
        full_q <= 1'b0;
      end else if (push && !req_ready_i) begin
        full_q <= 1'b1;
      end
    end
  end

  // Payload of the buffer
  always_ff @(posedge clk_i) begin
    if (push && !req_ready_i) begin
      data_q <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lane_dispatch.sv
// Lane dispatch stage
`default_nettype none

module lane_dispatch import lane_seq_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [lane_id_w-1:0] lane_id_i,
  input  vinsn_mask_t          pe_vinsn_running_i,
  // From the capture stage
  input  pe_req_t              req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Towards the issue registers
  lane_issue_if.dispatch       issue
);

  vinsn_mask_t running_q;
  vinsn_mask_t running_d;
  vinsn_mask_t running_now;
  vlen_t       lane_vl;
  vlen_t       lane_vstart;
  vlen_t       mask_vl;
  logic        needs_stall;
  logic        muted;
  logic        fire;

  // Builds one operand request command for the current instruction
  function automatic opq_cmd_t make_cmd(input pe_req_t req, input logic [4:0] vs,
                                        input vlen_t vl, input vlen_t vstart,
                                        input vinsn_mask_t hazard);
    opq_cmd_t cmd;
    cmd.id     = req.id;
    cmd.vs     = vs;
    cmd.eew    = req.vsew;
    cmd.vl     = vl;
    cmd.vstart = vstart;
    cmd.hazard = hazard;
    return cmd;
  endfunction

  //////////////////////////////
  // Lane length arithmetic
  //////////////////////////////

  always_comb begin
    // Elements are striped over lanes, low lanes take the remainder
    lane_vl = req_i.vl / vlen_t'(nr_lanes);
    if (lane_id_i < req_i.vl[lane_id_w-1:0]) begin
      lane_vl = lane_vl + vlen_t'(1);
    end
    lane_vstart = req_i.vstart / vlen_t'(nr_lanes);

    // Mask words are shared by all lanes, so round the count up
    mask_vl = (req_i.vl / vlen_t'(nr_lanes * mask_bits_per_byte)) >> unsigned'(req_i.vsew);
    if (vlen_t'((mask_vl << unsigned'(req_i.vsew)) * vlen_t'(nr_lanes * mask_bits_per_byte))
        != req_i.vl) begin
      mask_vl = mask_vl + vlen_t'(1);
    end
  end

  //////////////////////////////
  // Stall and handshake
  //////////////////////////////

  always_comb begin
    // Drop instructions the main sequencer no longer reports as running
    running_now = running_q & pe_vinsn_running_i;

    // Every slot the target unit may push has to be free
    case (req_i.vfu)
      vfu_alu: needs_stall = issue.opq_busy[opq_alu_a] || issue.opq_busy[opq_alu_b] ||
                             issue.opq_busy[opq_mask_m];
      vfu_mfpu: needs_stall = issue.opq_busy[opq_mfpu_a] || issue.opq_busy[opq_mfpu_b] ||
                              issue.opq_busy[opq_mfpu_c] || issue.opq_busy[opq_mask_m];
      default: needs_stall = 1'b0;
    endcase

    // An ID that is still running waits instead of being dropped
    req_ready_o = !needs_stall && !running_now[req_i.id];
    fire        = req_valid_i && req_ready_o;

    // Nothing for this lane to do
    muted = (req_i.vfu != vfu_none) && (lane_vl == '0);
  end

  //////////////////////////////
  // Command building
  //////////////////////////////

  always_comb begin
    running_d = running_now;

    // Sources go to A and B, the destination operand to C
    issue.opq_cmd[opq_alu_a]  = make_cmd(req_i, req_i.vs1, lane_vl, lane_vstart,
                                         req_i.hazard_vs1 | req_i.hazard_vd);
    issue.opq_cmd[opq_alu_b]  = make_cmd(req_i, req_i.vs2, lane_vl, lane_vstart,
                                         req_i.hazard_vs2 | req_i.hazard_vd);
    issue.opq_cmd[opq_mfpu_a] = make_cmd(req_i, req_i.vs1, lane_vl, lane_vstart,
                                         req_i.hazard_vs1 | req_i.hazard_vd);
    issue.opq_cmd[opq_mfpu_b] = make_cmd(req_i, req_i.vs2, lane_vl, lane_vstart,
                                         req_i.hazard_vs2 | req_i.hazard_vd);
    issue.opq_cmd[opq_mfpu_c] = make_cmd(req_i, req_i.vd, lane_vl, lane_vstart,
                                         req_i.hazard_vd);
    // The mask always lives in v0
    issue.opq_cmd[opq_mask_m] = make_cmd(req_i, 5'd0, mask_vl, lane_vstart,
                                         req_i.hazard_vm | req_i.hazard_vd);

    issue.vfu_op = '{
      id:        req_i.id,
      vfu:       req_i.vfu,
      op:        req_i.op,
      vm:        req_i.vm,
      vd:        req_i.vd,
      use_vs1:   req_i.use_vs1,
      use_vs2:   req_i.use_vs2,
      use_vd_op: req_i.use_vd_op,
      vsew:      req_i.vsew,
      vl:        lane_vl,
      vstart:    lane_vstart
    };

    issue.opq_push    = '0;
    issue.vfu_op_push = 1'b0;
    issue.muted_done  = '0;

    if (fire && muted) begin
      // Report completion directly, nothing gets issued
      issue.muted_done[req_i.id] = 1'b1;
    end else if (fire) begin
      case (req_i.vfu)
        vfu_alu: begin
          issue.opq_push[opq_alu_a]  = req_i.use_vs1;
          issue.opq_push[opq_alu_b]  = req_i.use_vs2;
          issue.opq_push[opq_mask_m] = !req_i.vm;
          issue.vfu_op_push          = 1'b1;
          running_d[req_i.id]        = 1'b1;
        end
        vfu_mfpu: begin
          issue.opq_push[opq_mfpu_a] = req_i.use_vs1;
          issue.opq_push[opq_mfpu_b] = req_i.use_vs2;
          issue.opq_push[opq_mfpu_c] = req_i.use_vd_op;
          issue.opq_push[opq_mask_m] = !req_i.vm;
          issue.vfu_op_push          = 1'b1;
          running_d[req_i.id]        = 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lane_issue_regs.sv
// Lane issue registers
`default_nettype none

module lane_issue_regs import lane_seq_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  lane_issue_if.issue           issue,
  // Operand requester slots
  output opq_cmd_t [nr_opq-1:0] operand_request_o,
  output logic     [nr_opq-1:0] operand_request_valid_o,
  input  logic     [nr_opq-1:0] operand_request_ready_i,
  // Functional units
  output vfu_op_t               vfu_operation_o,
  output logic                  vfu_operation_valid_o,
  input  vinsn_mask_t           alu_vinsn_done_i,
  input  vinsn_mask_t           mfpu_vinsn_done_i,
  output logic                  alu_vinsn_done_o,
  output logic                  mfpu_vinsn_done_o,
  // Completion report to the main sequencer
  output vinsn_mask_t           pe_resp_o
);

  logic [nr_opq-1:0] slot_valid_d;

  //////////////////////////////
  // Operand request slots
  //////////////////////////////

  always_comb begin
    for (int q = 0; q < nr_opq; q++) begin
      // Slot empties on a handshake, a fresh push takes priority
      slot_valid_d[q] = operand_request_valid_o[q] && !operand_request_ready_i[q];
      if (issue.opq_push[q]) begin
        slot_valid_d[q] = 1'b1;
      end
    end
  end

  // Dispatch stalls on any slot that still waits for its requester
  assign issue.opq_busy = operand_request_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_request_valid_o <= '0;
      vfu_operation_valid_o   <= 1'b0;
      pe_resp_o               <= '0;
      alu_vinsn_done_o        <= 1'b0;
      mfpu_vinsn_done_o       <= 1'b0;
    end else begin
      operand_request_valid_o <= slot_valid_d;
      // One-cycle pulse per issued operation
      vfu_operation_valid_o   <= issue.vfu_op_push;
      // Completion of any unit, plus lanes that had nothing to do
      pe_resp_o               <= alu_vinsn_done_i | mfpu_vinsn_done_i | issue.muted_done;
      alu_vinsn_done_o        <= |alu_vinsn_done_i;
      mfpu_vinsn_done_o       <= |mfpu_vinsn_done_i;
    end
  end

  // Payloads only change on a push
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < nr_opq; q++) begin
      if (issue.opq_push[q]) begin
        operand_request_o[q] <= issue.opq_cmd[q];
      end
    end
    if (issue.vfu_op_push) begin
      vfu_operation_o <= issue.vfu_op;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lane_sequencer.sv
// Lane sequencer top
`default_nettype none

module lane_sequencer import lane_seq_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [lane_id_w-1:0]  lane_id_i,
  // Main sequencer
  input  pe_req_t               pe_req_i,
  input  logic                  pe_req_valid_i,
  output logic                  pe_req_ready_o,
  input  vinsn_mask_t           pe_vinsn_running_i,
  output vinsn_mask_t           pe_resp_o,
  // Operand requester
  output opq_cmd_t [nr_opq-1:0] operand_request_o,
  output logic     [nr_opq-1:0] operand_request_valid_o,
  input  logic     [nr_opq-1:0] operand_request_ready_i,
  // Functional units
  output vfu_op_t               vfu_operation_o,
  output logic                  vfu_operation_valid_o,
  input  vinsn_mask_t           alu_vinsn_done_i,
  input  vinsn_mask_t           mfpu_vinsn_done_i,
  output logic                  alu_vinsn_done_o,
  output logic                  mfpu_vinsn_done_o
);

  // Capture to dispatch handshake
  pe_req_t req;
  logic    req_valid;
  logic    req_ready;

  lane_issue_if issue_if ();

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  lane_req_capture i_capture (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .req_o          (req),
    .req_valid_o    (req_valid),
    .req_ready_i    (req_ready)
  );

  lane_dispatch i_dispatch (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .lane_id_i          (lane_id_i),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .req_i              (req),
    .req_valid_i        (req_valid),
    .req_ready_o        (req_ready),
    .issue              (issue_if.dispatch)
  );

  lane_issue_regs i_issue (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .issue                   (issue_if.issue),
    .operand_request_o       (operand_request_o),
    .operand_request_valid_o (operand_request_valid_o),
    .operand_request_ready_i (operand_request_ready_i),
    .vfu_operation_o         (vfu_operation_o),
    .vfu_operation_valid_o   (vfu_operation_valid_o),
    .alu_vinsn_done_i        (alu_vinsn_done_i),
    .mfpu_vinsn_done_i       (mfpu_vinsn_done_i),
    .alu_vinsn_done_o        (alu_vinsn_done_o),
    .mfpu_vinsn_done_o       (mfpu_vinsn_done_o),
    .pe_resp_o               (pe_resp_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;

  // Reset low for 8 cycles, released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/lane_sequencer_assertions.sv
// Lane sequencer protocol assertions
`default_nettype none

module lane_sequencer_assertions import lane_seq_pkg::*; (
  input logic                  clk_i,
  input logic                  rst_ni,
  input opq_cmd_t [nr_opq-1:0] operand_request_o,
  input logic     [nr_opq-1:0] operand_request_valid_o,
  input logic     [nr_opq-1:0] operand_request_ready_i,
  input vfu_op_t               vfu_operation_o,
  input logic                  vfu_operation_valid_o,
  input vinsn_mask_t           pe_resp_o,
  input logic                  alu_vinsn_done_o,
  input logic                  mfpu_vinsn_done_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failures seen so far, read by the testbench at the end of the run
  int fail_count = 0;

  // All valids and done flags are low on the first edge out of reset
  assert property (@(posedge clk_i) $rose(rst_ni) |->
      (operand_request_valid_o == '0) && !vfu_operation_valid_o && (pe_resp_o == '0) &&
      !alu_vinsn_done_o && !mfpu_vinsn_done_o)
    else begin
      fail_count = fail_count + 1;
      $error("outputs active when reset was released");
    end

  // A command waiting for its requester must not move
  for (genvar q = 0; q < nr_opq; q++) begin : g_slot
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        operand_request_valid_o[q] && !operand_request_ready_i[q] |=>
        operand_request_valid_o[q] && $stable(operand_request_o[q]))
      else begin
        fail_count = fail_count + 1;
        $error("operand request slot %0d changed before ready", q);
      end
  end

  // An issued operation always targets a real unit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      vfu_operation_valid_o |-> vfu_operation_o.vfu != vfu_none)
    else begin
      fail_count = fail_count + 1;
      $error("operation issued with no target unit");
    end

endmodule

bind lane_sequencer lane_sequencer_assertions lane_assertions (
  .clk_i                   (clk_i),
  .rst_ni                  (rst_ni),
  .operand_request_o       (operand_request_o),
  .operand_request_valid_o (operand_request_valid_o),
  .operand_request_ready_i (operand_request_ready_i),
  .vfu_operation_o         (vfu_operation_o),
  .vfu_operation_valid_o   (vfu_operation_valid_o),
  .pe_resp_o               (pe_resp_o),
  .alu_vinsn_done_o        (alu_vinsn_done_o),
  .mfpu_vinsn_done_o       (mfpu_vinsn_done_o)
);

`default_nettype wire

//--- verification/tb_lane_sequencer.sv
// Lane sequencer testbench
`default_nettype none

module tb_lane_sequencer import lane_seq_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic rst_n;
  logic [lane_id_w-1:0] lane_id;
  pe_req_t pe_req;
  logic pe_req_valid;
  logic pe_req_ready;
  vinsn_mask_t pe_vinsn_running = '0;
  vinsn_mask_t pe_resp;
  opq_cmd_t [nr_opq-1:0] opq_req;
  logic [nr_opq-1:0] opq_valid;
  logic [nr_opq-1:0] opq_ready;
  vfu_op_t vfu_op;
  logic vfu_op_valid;
  vinsn_mask_t alu_done;
  vinsn_mask_t mfpu_done;
  logic alu_done_o;
  logic mfpu_done_o;

  // Expected traffic, in issue order
  vfu_op_t exp_op[$];
  opq_cmd_t exp_cmd[nr_opq][$];
  int ops_seen = 0;
  int issued_cnt[nr_vinsn] = '{default: 0};
  int retired_cnt[nr_vinsn] = '{default: 0};
  logic [31:0] lfsr = 32'h404a_38dc;

  tb_clock_gen clock_gen (.clk_o(clk), .rst_no(rst_n));

  lane_sequencer dut (
    .clk_i (clk), .rst_ni (rst_n), .lane_id_i (lane_id),
    .pe_req_i (pe_req), .pe_req_valid_i (pe_req_valid), .pe_req_ready_o (pe_req_ready),
    .pe_vinsn_running_i (pe_vinsn_running), .pe_resp_o (pe_resp),
    .operand_request_o (opq_req), .operand_request_valid_o (opq_valid),
    .operand_request_ready_i (opq_ready),
    .vfu_operation_o (vfu_op), .vfu_operation_valid_o (vfu_op_valid),
    .alu_vinsn_done_i (alu_done), .mfpu_vinsn_done_i (mfpu_done),
    .alu_vinsn_done_o (alu_done_o), .mfpu_vinsn_done_o (mfpu_done_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      abort_run("stopping at first mismatch");
    end
  endtask

  // Taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Expected lane work for one broadcast instruction
  function automatic void expected_issue(input pe_req_t r, input logic [lane_id_w-1:0] lane,
                                         output vfu_op_t op, output opq_cmd_t [nr_opq-1:0] cmd,
                                         output logic [nr_opq-1:0] push, output logic has_op);
    int unsigned lvl;
    int unsigned lvs;
    int unsigned mvl;
    int unsigned chunk;
    chunk = nr_lanes * mask_bits_per_byte;
    lvl = r.vl / nr_lanes;
    if (lane < (r.vl % nr_lanes)) lvl = lvl + 1;
    lvs = r.vstart / nr_lanes;
    // Mask bytes rounded up so every element has its bit
    mvl = (r.vl / chunk) >> r.vsew;
    if (((mvl << r.vsew) * chunk) != r.vl) mvl = mvl + 1;
    op = '{id: r.id, vfu: r.vfu, op: r.op, vm: r.vm, vd: r.vd, use_vs1: r.use_vs1,
           use_vs2: r.use_vs2, use_vd_op: r.use_vd_op, vsew: r.vsew,
           vl: vlen_t'(lvl), vstart: vlen_t'(lvs)};
    cmd[opq_alu_a]  = '{r.id, r.vs1, r.vsew, vlen_t'(lvl), vlen_t'(lvs), r.hazard_vs1 | r.hazard_vd};
    cmd[opq_alu_b]  = '{r.id, r.vs2, r.vsew, vlen_t'(lvl), vlen_t'(lvs), r.hazard_vs2 | r.hazard_vd};
    cmd[opq_mfpu_a] = cmd[opq_alu_a];
    cmd[opq_mfpu_b] = cmd[opq_alu_b];
    cmd[opq_mfpu_c] = '{r.id, r.vd, r.vsew, vlen_t'(lvl), vlen_t'(lvs), r.hazard_vd};
    cmd[opq_mask_m] = '{r.id, 5'd0, r.vsew, vlen_t'(mvl), vlen_t'(lvs), r.hazard_vm | r.hazard_vd};
    push   = '0;
    has_op = (lvl != 0) && (r.vfu != vfu_none);
    if (has_op && r.vfu == vfu_alu) begin
      push[opq_alu_a]  = r.use_vs1;
      push[opq_alu_b]  = r.use_vs2;
      push[opq_mask_m] = !r.vm;
    end else if (has_op) begin
      push[opq_mfpu_a] = r.use_vs1;
      push[opq_mfpu_b] = r.use_vs2;
      push[opq_mfpu_c] = r.use_vd_op;
      push[opq_mask_m] = !r.vm;
    end
  endfunction

  task automatic random_req(input vfu_e vfu, input vid_t id, output pe_req_t r);
    r = '0;
    r.id = id;
    r.vfu = vfu;
    r.op = 6'(take_bits(6));
    r.vm = 1'(take_bits(1));
    {r.vs1, r.vs2, r.vd} = 15'(take_bits(15));
    {r.use_vs1, r.use_vs2, r.use_vd_op} = 3'(take_bits(3));
    r.vl = vlen_t'(take_bits(10)) + vlen_t'(4);
    r.vstart = vlen_t'(take_bits(8));
    r.vsew = vsew_e'(2'(take_bits(2)));
    {r.hazard_vs1, r.hazard_vs2, r.hazard_vd, r.hazard_vm} = take_bits(32);
  endtask

  // Broadcast one request and hold it for extra cycles after the lane takes it
  task automatic send_req(input pe_req_t r, input int hold);
    vfu_op_t op;
    opq_cmd_t [nr_opq-1:0] cmd;
    logic [nr_opq-1:0] push;
    logic has_op;
    int t;
    @(posedge clk);
    pe_req <= r;
    pe_req_valid <= 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 100) abort_run("timeout waiting for pe_req_ready_o");
    end while (!pe_req_ready);
    // The main sequencer counts the instruction as running once it is broadcast
    issued_cnt[r.id] = issued_cnt[r.id] + 1;
    expected_issue(r, lane_id, op, cmd, push, has_op);
    if (has_op) exp_op.push_back(op);
    for (int q = 0; q < nr_opq; q++) begin
      if (push[q]) exp_cmd[q].push_back(cmd[q]);
    end
    @(posedge clk);
    for (int i = 0; i < hold; i++) @(posedge clk);
    pe_req_valid <= 1'b0;
  endtask

  // Wait until every expected output has been seen, then retire the ID
  task automatic drain(input vid_t id);
    int t;
    int pending;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 200) abort_run("timeout waiting for expected outputs to drain");
      pending = exp_op.size();
      for (int q = 0; q < nr_opq; q++) pending += exp_cmd[q].size();
    end while (pending != 0 || opq_valid != '0);
    retired_cnt[id] = retired_cnt[id] + 1;
  endtask

  // Main sequencer view of instructions still in flight
  always @(posedge clk) begin
    vinsn_mask_t m;
    for (int i = 0; i < nr_vinsn; i++) m[i] = issued_cnt[i] != retired_cnt[i];
    pe_vinsn_running <= m;
  end

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(negedge clk) begin
    vfu_op_t e;
    opq_cmd_t c;
    if (rst_n) begin
      if (vfu_op_valid) begin
        if (exp_op.size() == 0) abort_run("operation issued that no request called for");
        e = exp_op.pop_front();
        check_value("vfu_operation_o", 64'(vfu_op), 64'(e));
        ops_seen = ops_seen + 1;
      end
      // Commands are compared on the cycle their handshake completes
      for (int q = 0; q < nr_opq; q++) begin
        if (opq_valid[q] && opq_ready[q]) begin
          if (exp_cmd[q].size() == 0) abort_run("operand request issued that was not expected");
          c = exp_cmd[q].pop_front();
          check_value($sformatf("operand_request_o[%0d]", q), 64'(opq_req[q]), 64'(c));
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    pe_req_t r;
    int t;
    int seen;
    lane_id = 2'd1;
    pe_req = '0;
    pe_req_valid = 1'b0;
    opq_ready = '1;
    alu_done = '0;
    mfpu_done = '0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > 50) abort_run("timeout waiting for reset release");
    end while (!rst_n);

    // Random ALU and MFPU traffic
    for (int i = 0; i < 16; i++) begin
      random_req(vfu_alu, vid_t'(i), r);
      send_req(r, 0);
      drain(r.id);
    end
    for (int i = 0; i < 16; i++) begin
      random_req(vfu_mfpu, vid_t'(i + 3), r);
      send_req(r, 0);
      drain(r.id);
    end

    // A request for no unit is taken and leaves nothing behind
    random_req(vfu_none, 3'd4, r);
    send_req(r, 0);
    drain(r.id);

    // Lane 3 gets no element of a two element vector
    @(posedge clk);
    lane_id <= 2'd3;
    random_req(vfu_alu, 3'd5, r);
    r.vl = 16'd2;
    send_req(r, 0);
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 20) abort_run("muted instruction never reported on pe_resp_o");
    end while (!pe_resp[5]);
    drain(r.id);
    @(posedge clk);
    lane_id <= 2'd1;

    // Held broadcast issues once, a reused ID issues again
    random_req(vfu_mfpu, 3'd6, r);
    seen = ops_seen;
    send_req(r, 10);
    drain(r.id);
    check_value("operation count", 64'(ops_seen - seen), 64'd1);
    send_req(r, 0);
    drain(r.id);
    check_value("operation count", 64'(ops_seen - seen), 64'd2);

    // Back-pressure from the operand requesters
    @(posedge clk);
    opq_ready <= '0;
    random_req(vfu_alu, 3'd1, r);
    r.use_vs1 = 1'b1;
    send_req(r, 0);
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 20) abort_run("first alu_a command never became valid");
    end while (!opq_valid[opq_alu_a]);
    random_req(vfu_alu, 3'd2, r);
    send_req(r, 0);
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 20) abort_run("pe_req_ready_o did not fall while stalled");
    end while (pe_req_ready);
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_value("operand_request_o[0]", 64'(opq_req[opq_alu_a]),
                  64'(exp_cmd[opq_alu_a][0]));
      check_value("pe_req_ready_o", 64'(pe_req_ready), 64'd0);
    end
    @(posedge clk);
    opq_ready <= '1;
    drain(3'd1);
    retired_cnt[2] = retired_cnt[2] + 1;

    // Done pulses come back one cycle later
    @(posedge clk);
    alu_done <= 8'h24;
    @(negedge clk);
    check_value("pe_resp_o", 64'(pe_resp), 64'h0);
    @(posedge clk);
    alu_done <= '0;
    mfpu_done <= 8'h81;
    @(negedge clk);
    check_value("pe_resp_o", 64'(pe_resp), 64'h24);
    check_value("alu_vinsn_done_o", 64'(alu_done_o), 64'd1);
    check_value("mfpu_vinsn_done_o", 64'(mfpu_done_o), 64'd0);
    @(posedge clk);
    mfpu_done <= '0;
    @(negedge clk);
    check_value("pe_resp_o", 64'(pe_resp), 64'h81);
    check_value("mfpu_vinsn_done_o", 64'(mfpu_done_o), 64'd1);
    check_value("alu_vinsn_done_o", 64'(alu_done_o), 64'd0);

    repeat (4) @(negedge clk);
    if (dut.lane_assertions.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("protocol assertions failed");
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- lane_sequencer.f
rtl/lane_seq_pkg.sv
rtl/lane_issue_if.sv
rtl/lane_req_capture.sv
rtl/lane_dispatch.sv
rtl/lane_issue_regs.sv
rtl/lane_sequencer.sv
verification/tb_clock_gen.sv
verification/lane_sequencer_assertions.sv
verification/tb_lane_sequencer.sv

//--- Bender.yml
package:
  name: lane_sequencer

sources:
  - rtl/lane_seq_pkg.sv
  - rtl/lane_issue_if.sv
  - rtl/lane_req_capture.sv
  - rtl/lane_dispatch.sv
  - rtl/lane_issue_regs.sv
  - rtl/lane_sequencer.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/lane_sequencer_assertions.sv
      - verification/tb_lane_sequencer.sv
